// File: hdl/p_hit_settings.svh
`ifndef P_HIT_SETTINGS_SVH
`define P_HIT_SETTINGS_SVH

// fraction bits of the Q format used by every dot product
`define PH_Q_BITS 10

`define PH_IN_DEPTH 16   // jobs waiting for the lanes
`define PH_OUT_DEPTH 16  // finished results waiting for the reader

`define PH_LANES 3
`define PH_TAG_W 8

`endif

// File: hdl/p_hit_pkg.sv
`include "p_hit_settings.svh"

package p_hit_pkg;

    typedef struct packed {
        logic signed [31:0] x;
        logic signed [31:0] y;
        logic signed [31:0] z;
    } vec3_t;

    // one plane-crossing job as written by the producer
    typedef struct packed {
        logic [`PH_TAG_W-1:0] tag;
        vec3_t                normal;
        vec3_t                v0;
        vec3_t                origin;
        vec3_t                dir;
    } hit_job_t;

    typedef struct packed {
        vec3_t a;
        vec3_t b;
    } dot_pair_t;

    typedef struct packed {
        logic [`PH_TAG_W-1:0] tag;
        logic signed [31:0]   t_num;
        logic signed [31:0]   t_den;
        logic                 hit;
    } hit_result_t;

    typedef enum logic [1:0] {LANE_V0, LANE_ORIGIN, LANE_DIR} lane_e;  // dot lane index

endpackage

// File: hdl/sync_fifo.sv
`timescale 1ns/100ps

module sync_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 16
) (
    input  logic             clock,
    input  logic             rst_n,
    input  logic             wr_en,
    input  logic [WIDTH-1:0] din,
    output logic             full,
    input  logic             rd_en,
    output logic [WIDTH-1:0] dout,
    output logic             empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             wr_ok;
    logic             rd_ok;

    assign wr_ok = wr_en && !full;
    assign rd_ok = rd_en && !empty;

    always_ff @(posedge clock) begin
        if (wr_ok)
            mem[wr_ptr] <= din;
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_ok)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (rd_ok)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({wr_ok, rd_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign full  = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);
    assign dout  = mem[rd_ptr];  // first word falls through

    // both strobes come from the surrounding logic and must honour the levels
    assert property (@(posedge clock) disable iff (!rst_n) wr_en |-> !full)
        else $error("sync_fifo: write while full");

    assert property (@(posedge clock) disable iff (!rst_n) rd_en |-> !empty)
        else $error("sync_fifo: read while empty");

endmodule

// File: hdl/p_hit_fifo_in.sv
`timescale 1ns/100ps

`include "p_hit_settings.svh"

module p_hit_fifo_in import p_hit_pkg::*; (
    input  logic                 clock,
    input  logic                 rst_n,
    input  hit_job_t             job,
    input  logic                 wr_en,
    output logic                 full,
    output dot_pair_t            pairs [`PH_LANES],
    output logic [`PH_TAG_W-1:0] tag,
    output logic                 empty,
    input  logic [`PH_LANES-1:0] rd_en
);

    hit_job_t head;

    sync_fifo #(
        .WIDTH  ($bits(hit_job_t)),
        .DEPTH  (`PH_IN_DEPTH)
    ) u_job_fifo (
        .clock  (clock),
        .rst_n  (rst_n),
        .wr_en  (wr_en),
        .din    (job),
        .full   (full),
        .rd_en  (rd_en[LANE_V0]),  // the lanes move together so one strobe pops
        .dout   (head),
        .empty  (empty)
    );

    // the normal is shared by all three products
    always_comb begin
        pairs[LANE_V0].a     = head.normal;
        pairs[LANE_V0].b     = head.v0;
        pairs[LANE_ORIGIN].a = head.normal;
        pairs[LANE_ORIGIN].b = head.origin;
        pairs[LANE_DIR].a    = head.normal;
        pairs[LANE_DIR].b    = head.dir;
    end

    assign tag = head.tag;

    // a lane that read alone would shift its results against the others
    assert property (@(posedge clock) disable iff (!rst_n)
        rd_en == {`PH_LANES{rd_en[0]}})
        else $error("p_hit_fifo_in: lane read strobes disagree (%b)", rd_en);

endmodule

// File: hdl/fixed_dot3.sv
`timescale 1ns/100ps

`include "p_hit_settings.svh"

module fixed_dot3 import p_hit_pkg::*; (
    input  logic               clock,
    input  logic               rst_n,
    input  dot_pair_t          pair,
    input  logic               in_empty,
    output logic               in_rd_en,
    output logic signed [31:0] out,
    output logic               out_empty,
    input  logic               out_rd_en
);

    localparam int BUF_DEPTH = 4;
    localparam int PTR_W     = $clog2(BUF_DEPTH);

    logic signed [63:0] prod [3];
    logic               s1_valid;
    logic signed [63:0] sum;
    logic signed [63:0] sum_shift;
    logic signed [31:0] s2_dot;
    logic               s2_valid;
    logic signed [31:0] obuf [BUF_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [PTR_W:0]     buf_count;
    logic [PTR_W:0]     credit;  // pairs in the pipeline plus results in the buffer

    // operands are sign extended so the low 64 bits of the product are exact
    function automatic logic signed [63:0] mul64(input logic signed [31:0] a,
                                                 input logic signed [31:0] b);
        return {{32{a[31]}}, a} * {{32{b[31]}}, b};
    endfunction

    assign in_rd_en = !in_empty && (credit < (PTR_W + 1)'(BUF_DEPTH));

    always_comb begin
        sum       = prod[0] + prod[1] + prod[2];
        sum_shift = sum >>> `PH_Q_BITS;
    end

    always_ff @(posedge clock) begin
        if (in_rd_en) begin
            prod[0] <= mul64(pair.a.x, pair.b.x);
            prod[1] <= mul64(pair.a.y, pair.b.y);
            prod[2] <= mul64(pair.a.z, pair.b.z);
        end
        if (s1_valid)
            s2_dot <= sum_shift[31:0];
        if (s2_valid)
            obuf[wr_ptr] <= s2_dot;
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid  <= 1'b0;
            s2_valid  <= 1'b0;
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            buf_count <= '0;
            credit    <= '0;
        end else begin
            s1_valid <= in_rd_en;
            s2_valid <= s1_valid;
            if (s2_valid)
                wr_ptr <= wr_ptr + 1'b1;
            if (out_rd_en)
                rd_ptr <= rd_ptr + 1'b1;
            buf_count <= buf_count + s2_valid - out_rd_en;
            credit    <= credit + in_rd_en - out_rd_en;
        end
    end

    assign out       = obuf[rd_ptr];
    assign out_empty = (buf_count == '0);

    assert property (@(posedge clock) disable iff (!rst_n) out_rd_en |-> !out_empty)
        else $error("fixed_dot3: output read while empty");

endmodule

// File: hdl/p_hit_combine.sv
`timescale 1ns/100ps

`include "p_hit_settings.svh"

module p_hit_combine import p_hit_pkg::*; (
    input  logic                 clock,
    input  logic                 rst_n,
    input  logic signed [31:0]   dots [`PH_LANES],
    input  logic [`PH_LANES-1:0] dots_empty,
    input  logic [`PH_TAG_W-1:0] tag,
    input  logic                 tag_wr,
    output logic                 dots_rd_en,
    output hit_result_t          result,
    input  logic                 out_rd_en,
    output logic                 out_empty
);

    // never more tags in flight than one lane can hold
    localparam int TAG_DEPTH = 4;

    logic [`PH_TAG_W-1:0] tag_head;
    logic                 tag_empty;
    logic signed [31:0]   t_num;
    logic signed [31:0]   t_den;
    logic                 hit;
    hit_result_t          stage_q;
    logic                 stage_valid;
    logic                 res_wr_en;
    logic                 res_full;

    sync_fifo #(
        .WIDTH  (`PH_TAG_W),
        .DEPTH  (TAG_DEPTH)
    ) u_tag_fifo (
        .clock  (clock),
        .rst_n  (rst_n),
        .wr_en  (tag_wr),
        .din    (tag),
        .full   (),
        .rd_en  (dots_rd_en),
        .dout   (tag_head),
        .empty  (tag_empty)
    );

    always_comb begin
        t_num = dots[LANE_V0] - dots[LANE_ORIGIN];  // wraps at 32 bits
        t_den = dots[LANE_DIR];
        // parallel rays never hit; otherwise t must not be negative
        hit   = (t_den != '0) && ((t_num == '0) || (t_num[31] == t_den[31]));
    end

    assign dots_rd_en = !(|dots_empty) && !tag_empty && !res_full;
    assign res_wr_en  = stage_valid && !res_full;

    always_ff @(posedge clock) begin
        if (dots_rd_en) begin
            stage_q.tag   <= tag_head;
            stage_q.t_num <= t_num;
            stage_q.t_den <= t_den;
            stage_q.hit   <= hit;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n)
            stage_valid <= 1'b0;
        else if (dots_rd_en)
            stage_valid <= 1'b1;
        else if (res_wr_en)
            stage_valid <= 1'b0;
    end

    sync_fifo #(
        .WIDTH  ($bits(hit_result_t)),
        .DEPTH  (`PH_OUT_DEPTH)
    ) u_result_fifo (
        .clock  (clock),
        .rst_n  (rst_n),
        .wr_en  (res_wr_en),
        .din    (stage_q),
        .full   (res_full),
        .rd_en  (out_rd_en),
        .dout   (result),
        .empty  (out_empty)
    );

    // every set of lane results was read from the job FIFO together with its tag
    assert property (@(posedge clock) disable iff (!rst_n)
        !(|dots_empty) |-> !tag_empty)
        else $error("p_hit_combine: lane results present with no tag");

endmodule

// File: hdl/p_hit_top.sv
`timescale 1ns/100ps

`include "p_hit_settings.svh"

module p_hit_top import p_hit_pkg::*; (
    input  logic        clock,
    input  logic        rst_n,
    input  hit_job_t    job,
    input  logic        in_wr_en,
    output logic        in_full,
    output hit_result_t result,
    input  logic        out_rd_en,
    output logic        out_empty
);

    dot_pair_t            pairs [`PH_LANES];
    logic [`PH_TAG_W-1:0] head_tag;
    logic                 job_empty;
    logic [`PH_LANES-1:0] lane_rd_en;
    logic signed [31:0]   dot_out [`PH_LANES];
    logic [`PH_LANES-1:0] dot_empty;
    logic                 dots_rd_en;

    p_hit_fifo_in u_fifo_in (
        .clock       (clock),
        .rst_n       (rst_n),
        .job         (job),
        .wr_en       (in_wr_en),
        .full        (in_full),
        .pairs       (pairs),
        .tag         (head_tag),
        .empty       (job_empty),
        .rd_en       (lane_rd_en)
    );

    // identical lanes see the same empty level and pop, so they stay in step
    for (genvar i = 0; i < `PH_LANES; i++) begin : g_lane
        fixed_dot3 u_lane (
            .clock       (clock),
            .rst_n       (rst_n),
            .pair        (pairs[i]),
            .in_empty    (job_empty),
            .in_rd_en    (lane_rd_en[i]),
            .out         (dot_out[i]),
            .out_empty   (dot_empty[i]),
            .out_rd_en   (dots_rd_en)
        );
    end

    p_hit_combine u_combine (
        .clock       (clock),
        .rst_n       (rst_n),
        .dots        (dot_out),
        .dots_empty  (dot_empty),
        .tag         (head_tag),
        .tag_wr      (lane_rd_en[LANE_V0]),  // tag leaves the job FIFO with its pairs
        .dots_rd_en  (dots_rd_en),
        .result      (result),
        .out_rd_en   (out_rd_en),
        .out_empty   (out_empty)
    );

endmodule

// File: sim/p_hit_tb.sv
`timescale 1ns/100ps

`include "p_hit_settings.svh"

module p_hit_tb import p_hit_pkg::*; ();

    localparam int ONE         = 1 << `PH_Q_BITS;  // 1.0 in the Q format
    localparam int READ_HOLD   = 0;
    localparam int READ_ALWAYS = 1;
    localparam int READ_RANDOM = 2;

    logic        clock;
    logic        rst_n;
    hit_job_t    job;
    logic        in_wr_en;
    logic        in_full;
    hit_result_t result;
    logic        out_rd_en;
    logic        out_empty;

    hit_result_t          model_q [$];
    hit_result_t          exp_head = '0;  // oldest result still owed by the DUT
    hit_result_t          last_result = '0;
    int                   model_count = 0;
    int                   pop_count = 0;
    int                   error_count = 0;
    int                   tests_passed = 0;
    int                   tests_failed = 0;
    int                   read_mode = READ_HOLD;
    int                   stall_idx = 0;
    bit                   stall_pat [64];
    logic [`PH_TAG_W-1:0] next_tag;

    p_hit_top u_p_hit_top (
        .clock      (clock),
        .rst_n      (rst_n),
        .job        (job),
        .in_wr_en   (in_wr_en),
        .in_full    (in_full),
        .result     (result),
        .out_rd_en  (out_rd_en),
        .out_empty  (out_empty)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // the dot product is summed at 64 bits and scaled back by the fraction bits
    function automatic logic signed [31:0] dot_q(input vec3_t a, input vec3_t b);
        longint acc;
        acc = longint'(a.x) * longint'(b.x) + longint'(a.y) * longint'(b.y)
            + longint'(a.z) * longint'(b.z);
        acc = acc >>> `PH_Q_BITS;
        return acc[31:0];
    endfunction

    function automatic hit_result_t model_result(input hit_job_t j);
        hit_result_t r;
        r.tag   = j.tag;
        r.t_num = dot_q(j.normal, j.v0) - dot_q(j.normal, j.origin);
        r.t_den = dot_q(j.normal, j.dir);
        r.hit   = (r.t_den != 0) && ((r.t_num == 0) || ((r.t_num < 0) == (r.t_den < 0)));
        return r;
    endfunction

    function automatic vec3_t make_vec(input int x, input int y, input int z);
        vec3_t v;
        v.x = x;
        v.y = y;
        v.z = z;
        return v;
    endfunction

    function automatic hit_job_t make_job(input vec3_t normal, input vec3_t v0,
                                          input vec3_t origin, input vec3_t dir);
        hit_job_t j;
        j.tag    = '0;
        j.normal = normal;
        j.v0     = v0;
        j.origin = origin;
        j.dir    = dir;
        return j;
    endfunction

    // coordinates within +-64.0 keep every sum inside 64 bits
    function automatic int rand_coord();
        return int'($urandom_range(0, 131072)) - 65536;
    endfunction

    function automatic vec3_t rand_vec();
        return make_vec(rand_coord(), rand_coord(), rand_coord());
    endfunction

    function automatic hit_job_t random_job();
        hit_job_t j;
        j = make_job(rand_vec(), rand_vec(), rand_vec(), rand_vec());
        if ($urandom_range(0, 7) == 0)
            j.dir = '0;  // now and then a ray parallel to every plane
        return j;
    endfunction

    always @(posedge clock) begin
        if (rst_n) begin
            if (out_rd_en && !out_empty && model_q.size() > 0) begin
                last_result = result;
                void'(model_q.pop_front());
                pop_count++;
            end
            if (in_wr_en && !in_full)
                model_q.push_back(model_result(job));
            model_count = model_q.size();
            exp_head    = (model_q.size() > 0) ? model_q[0] : '0;
        end
    end

    assert property (@(posedge clock) disable iff (!rst_n)
        out_rd_en |-> !out_empty && model_count > 0)
        else begin
            $display("result popped with no result present or no job outstanding");
            error_count++;
        end

    assert property (@(posedge clock) disable iff (!rst_n) out_rd_en |-> result.tag == exp_head.tag)
        else begin
            $display("[FAIL] result.tag got 0x%h expected 0x%h",
                     $sampled(result.tag), $sampled(exp_head.tag));
            error_count++;
        end

    assert property (@(posedge clock) disable iff (!rst_n)
        out_rd_en |-> result.t_num == exp_head.t_num)
        else begin
            $display("[FAIL] result.t_num got 0x%h expected 0x%h",
                     $sampled(result.t_num), $sampled(exp_head.t_num));
            error_count++;
        end

    assert property (@(posedge clock) disable iff (!rst_n)
        out_rd_en |-> result.t_den == exp_head.t_den)
        else begin
            $display("[FAIL] result.t_den got 0x%h expected 0x%h",
                     $sampled(result.t_den), $sampled(exp_head.t_den));
            error_count++;
        end

    assert property (@(posedge clock) disable iff (!rst_n) out_rd_en |-> result.hit == exp_head.hit)
        else begin
            $display("[FAIL] result.hit got 0x%h expected 0x%h",
                     $sampled(result.hit), $sampled(exp_head.hit));
            error_count++;
        end

    // the reader pops only what is already there
    initial begin
        out_rd_en = 1'b0;
        forever begin
            @(negedge clock);
            if (!rst_n || out_empty || read_mode == READ_HOLD)
                out_rd_en = 1'b0;
            else if (read_mode == READ_RANDOM)
                out_rd_en = !stall_pat[stall_idx];
            else
                out_rd_en = 1'b1;
            stall_idx = (stall_idx + 1) % 64;
        end
    end

    task automatic check_bit(input string name, input logic got, input logic expected);
        assert (got === expected)
        else begin
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, expected);
            error_count++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int expected);
        assert (got == expected)
        else begin
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, expected);
            error_count++;
        end
    endtask

    // called on a falling edge, returns on the falling edge after the write
    task automatic write_job(input hit_job_t j);
        int waited;
        waited = 0;
        while (in_full && waited < 1000) begin
            @(negedge clock);
            waited++;
        end
        if (in_full) begin
            $display("timed out waiting for room in the input FIFO");
            error_count++;
        end else begin
            job     = j;
            job.tag = next_tag;
            next_tag++;
            in_wr_en = 1'b1;
            @(negedge clock);
            in_wr_en = 1'b0;
        end
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (model_count != 0 && waited < 2000) begin
            @(negedge clock);
            waited++;
        end
        if (model_count != 0) begin
            $display("timed out with %0d results still outstanding", model_count);
            error_count++;
        end
        @(negedge clock);
        check_bit("out_empty", out_empty, 1'b1);  // nothing beyond the expected results
    endtask

    task automatic end_test(input string name, input int errors_before);
        if (error_count == errors_before) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, error_count - errors_before);
        end
    endtask

    task automatic run_reset_state();
        int errors_before;
        errors_before = error_count;
        check_bit("out_empty", out_empty, 1'b1);
        check_bit("in_full", in_full, 1'b0);
        end_test("reset_state", errors_before);
    endtask

    task automatic run_single_job();
        int errors_before;
        errors_before = error_count;
        read_mode = READ_ALWAYS;
        // plane z = 5.0 seen from the origin straight along +z
        write_job(make_job(make_vec(0, 0, ONE), make_vec(0, 0, 5 * ONE),
                           make_vec(0, 0, 0), make_vec(0, 0, ONE)));
        wait_drained();
        check_bit("result.hit", last_result.hit, 1'b1);
        end_test("single_job", errors_before);
    endtask

    task automatic run_miss_cases();
        int errors_before;
        errors_before = error_count;
        read_mode = READ_ALWAYS;
        write_job(make_job(make_vec(0, 0, ONE), make_vec(0, 0, 5 * ONE),
                           make_vec(0, 0, 0), make_vec(ONE, 0, 0)));
        wait_drained();
        check_bit("result.hit", last_result.hit, 1'b0);
        write_job(make_job(make_vec(0, 0, ONE), make_vec(0, 0, -5 * ONE),
                           make_vec(0, 0, 0), make_vec(0, 0, ONE)));
        wait_drained();
        check_bit("result.hit", last_result.hit, 1'b0);
        end_test("miss_cases", errors_before);
    endtask

    task automatic run_random_jobs();
        int errors_before;
        int pops_before;
        errors_before = error_count;
        pops_before   = pop_count;
        read_mode     = READ_RANDOM;
        for (int n = 0; n < 200; n++) begin
            write_job(random_job());
            if ($urandom_range(0, 3) == 0)
                @(negedge clock);
        end
        read_mode = READ_ALWAYS;
        wait_drained();
        check_count("pop_count", pop_count - pops_before, 200);
        check_count("model_q.size", model_q.size(), 0);
        end_test("random_jobs", errors_before);
    endtask

    task automatic run_back_pressure();
        int errors_before;
        int pops_before;
        int written;
        int waited;
        errors_before = error_count;
        pops_before   = pop_count;
        written       = 0;
        waited        = 0;
        read_mode     = READ_HOLD;
        while (!in_full && waited < 200) begin
            job     = random_job();
            job.tag = next_tag;
            next_tag++;
            in_wr_en = 1'b1;
            @(negedge clock);
            written++;
            waited++;
        end
        in_wr_en = 1'b0;
        if (!in_full)
            $display("timed out waiting for in_full to rise");
        check_bit("in_full", in_full, 1'b1);
        read_mode = READ_ALWAYS;
        wait_drained();
        check_count("pop_count", pop_count - pops_before, written);
        end_test("back_pressure", errors_before);
    endtask

    task automatic finish_run();
        $display("tests passed %0d, failed %0d, errors %0d",
                 tests_passed, tests_failed, error_count);
        if (error_count == 0 && tests_failed == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    endtask

    initial begin
        #500_000;
        $display("simulation time limit reached");
        error_count++;
        finish_run();
    end

    initial begin
        void'($urandom(35045));
        rst_n    = 1'b0;
        job      = '0;
        in_wr_en = 1'b0;
        next_tag = '0;
        foreach (stall_pat[i])
            stall_pat[i] = ($urandom_range(0, 3) == 0);
        repeat (8) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;
        run_reset_state();
        run_single_job();
        run_miss_cases();
        run_random_jobs();
        run_back_pressure();
        finish_run();
    end

endmodule

// File: Bender.yml
package:
  name: p_hit

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/p_hit_pkg.sv
      - hdl/sync_fifo.sv
      - hdl/p_hit_fifo_in.sv
      - hdl/fixed_dot3.sv
      - hdl/p_hit_combine.sv
      - hdl/p_hit_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - sim/p_hit_tb.sv

// File: p_hit_top.f
+incdir+hdl
hdl/p_hit_pkg.sv
hdl/sync_fifo.sv
hdl/p_hit_fifo_in.sv
hdl/fixed_dot3.sv
hdl/p_hit_combine.sv
hdl/p_hit_top.sv
sim/p_hit_tb.sv
